// File: design/psgPkg.sv
`default_nettype none

package psgPkg;

	// ============================================================
	// sample format
	// ============================================================

	// one stored wave-table sample, two's complement
	localparam int SampleWidth = 8;

	typedef logic signed [SampleWidth-1:0] sample_t;

	// ============================================================
	// phase accumulator layout
	// ============================================================

	// upper bits index the table, lower bits are the fraction
	localparam int PhaseWidth = 16;
	localparam int FracWidth = 8;
	localparam int IndexWidth = PhaseWidth - FracWidth;

	// register write opcodes
	typedef enum logic [1:0] {
		REG_START  = 2'd0,
		REG_LENGTH = 2'd1,
		REG_STEP   = 2'd2,
		REG_CTRL   = 2'd3
	} regOp_t;

	// channel playback states
	typedef enum logic [1:0] {
		CH_IDLE  = 2'd0,
		CH_PLAY  = 2'd1,
		CH_FETCH = 2'd2
	} chanState_t;

endpackage

`default_nettype wire

// File: design/psgRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module psgRegFile #(
	parameter int NumChannels = 8,
	parameter int AdrWidth = 16,
	localparam int ChanBits = (NumChannels > 1) ? $clog2(NumChannels) : 1
) (
	input logic clk,
	input logic rst,

	// register write port
	input logic regWr,
	input logic [ChanBits-1:0] regChan,
	input psgPkg::regOp_t regOp,
	input logic [15:0] regData,

	// per-channel settings, one slice per channel
	output logic [NumChannels*AdrWidth-1:0] chanStart,
	output logic [NumChannels*psgPkg::IndexWidth-1:0] chanLength,
	output logic [NumChannels*psgPkg::PhaseWidth-1:0] chanStep,
	output logic [NumChannels-1:0] chanEnable
);

	// ============================================================
	// write decode
	// ============================================================

	// each write lands in exactly one channel's field
	always_ff @(posedge clk) begin
		if (rst) begin
			chanStart <= '0;
			chanLength <= '0;
			chanStep <= '0;
			chanEnable <= '0;
		end
		else if (regWr) begin
			for (int i = 0; i < NumChannels; i++) begin
				if (regChan == ChanBits'(i)) begin
					case (regOp)
					psgPkg::REG_START: begin
						// table base in system memory
						chanStart[i*AdrWidth +: AdrWidth] <= AdrWidth'(regData);
					end
					psgPkg::REG_LENGTH: begin
						// number of table entries, zero means full index range
						chanLength[i*psgPkg::IndexWidth +: psgPkg::IndexWidth] <=
							regData[psgPkg::IndexWidth-1:0];
					end
					psgPkg::REG_STEP: begin
						chanStep[i*psgPkg::PhaseWidth +: psgPkg::PhaseWidth] <=
							psgPkg::PhaseWidth'(regData);
					end
					psgPkg::REG_CTRL: begin
						// bit 0 starts and stops playback
						chanEnable[i] <= regData[0];
					end
					default: begin
						chanEnable[i] <= chanEnable[i];
					end
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/psgWaveChannel.sv
`timescale 1ns/1ps
`default_nettype none

module psgWaveChannel #(
	parameter int AdrWidth = 16
) (
	input logic clk,
	input logic rst,
	input logic ce,

	// settings from the register file
	input logic [AdrWidth-1:0] start,
	input logic [psgPkg::IndexWidth-1:0] length,
	input logic [psgPkg::PhaseWidth-1:0] step,
	input logic enable,

	// bus side
	input logic fetchDone,
	input psgPkg::sample_t busDat,
	output logic req,
	output logic [AdrWidth-1:0] adr,

	// current sample for the mixer
	output psgPkg::sample_t sample
);

	psgPkg::chanState_t state;
	logic [psgPkg::PhaseWidth-1:0] phase;
	logic [psgPkg::PhaseWidth:0] sumPhase;
	logic [psgPkg::PhaseWidth-1:0] nextPhase;
	logic [psgPkg::IndexWidth-1:0] index;
	logic [psgPkg::IndexWidth-1:0] nextIndex;
	logic indexChange;

	// ============================================================
	// phase accumulator
	// ============================================================

	assign index = phase[psgPkg::PhaseWidth-1 -: psgPkg::IndexWidth];

	// one extra bit so the wrap compare sees the carry
	always_comb begin
		sumPhase = {1'b0, phase} + {1'b0, step};
		nextPhase = sumPhase[psgPkg::PhaseWidth-1:0];
		if (length != '0 && sumPhase[psgPkg::PhaseWidth:psgPkg::FracWidth] >= {1'b0, length}) begin
			nextPhase = psgPkg::PhaseWidth'(sumPhase -
				{1'b0, length, {psgPkg::FracWidth{1'b0}}});
		end
	end

	assign nextIndex = nextPhase[psgPkg::PhaseWidth-1 -: psgPkg::IndexWidth];
	assign indexChange = ce && (nextIndex != index);

	// ============================================================
	// playback FSM
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst || !enable) begin
			state <= psgPkg::CH_IDLE;
			phase <= '0;
			sample <= '0;
		end
		else begin
			case (state)
			psgPkg::CH_IDLE: begin
				// enable just rose, fetch entry zero first
				state <= psgPkg::CH_FETCH;
			end
			psgPkg::CH_PLAY: begin
				if (ce) begin
					phase <= nextPhase;
				end
				if (indexChange) begin
					state <= psgPkg::CH_FETCH;
				end
			end
			psgPkg::CH_FETCH: begin
				// phase keeps running while the bus is busy
				if (ce) begin
					phase <= nextPhase;
				end
				if (fetchDone) begin
					sample <= busDat;
					if (!indexChange) begin
						state <= psgPkg::CH_PLAY;
					end
				end
			end
			default: begin
				state <= psgPkg::CH_IDLE;
			end
			endcase
		end
	end

	assign req = (state == psgPkg::CH_FETCH);

	// address follows the live index, so slow fetches skip entries
	assign adr = start + AdrWidth'(index);

endmodule

`default_nettype wire

// File: design/psgBusArb.sv
`timescale 1ns/1ps
`default_nettype none

module psgBusArb #(
	parameter int NumChannels = 8,
	parameter int AdrWidth = 16,
	localparam int ChanBits = (NumChannels > 1) ? $clog2(NumChannels) : 1
) (
	input logic clk,
	input logic rst,
	input logic ce,

	// transfer completed on the system bus
	input logic busAck,

	// channel requests and their fetch addresses
	input logic [NumChannels-1:0] chanReq,
	input logic [NumChannels*AdrWidth-1:0] chanAdr,

	// grant, owner index and completion pulses
	output logic [NumChannels-1:0] sel,
	output logic [ChanBits-1:0] seln,
	output logic [NumChannels-1:0] fetchDone,

	// request toward the next level of the tree
	output logic busReq,
	output logic [AdrWidth-1:0] busAdr
);

	logic [NumChannels-1:0] standing;
	logic [NumChannels-1:0] nextSel;
	logic [ChanBits-1:0] nextSeln;

	// the owner finishes only on an acknowledged, enabled cycle
	assign fetchDone = sel & chanReq & {NumChannels{ce & busAck}};

	// requests that survive this edge's completions
	assign standing = chanReq & ~fetchDone;

	// ============================================================
	// fixed priority, lowest index wins
	// ============================================================

	always_comb begin
		nextSel = '0;
		nextSeln = '0;
		for (int i = NumChannels - 1; i >= 0; i--) begin
			if (standing[i]) begin
				nextSel = '0;
				nextSel[i] = 1'b1;
				nextSeln = ChanBits'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
			seln <= '0;
		end
		// with nobody left asking, keep the last owner
		else if (ce && busAck && (standing != '0)) begin
			sel <= nextSel;
			seln <= nextSeln;
		end
	end

	assign busReq = |chanReq;
	assign busAdr = chanAdr[seln*AdrWidth +: AdrWidth];

endmodule

`default_nettype wire

// File: design/psgMixer.sv
`timescale 1ns/1ps
`default_nettype none

module psgMixer #(
	parameter int NumChannels = 8,
	localparam int OutWidth = psgPkg::SampleWidth + $clog2(NumChannels)
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic [NumChannels*psgPkg::SampleWidth-1:0] chanSample,
	output logic signed [OutWidth-1:0] audioOut
);

	logic signed [OutWidth-1:0] total;

	// ============================================================
	// signed sum of all voices
	// ============================================================

	// headroom bits cover the worst case of every voice at full scale
	always_comb begin
		total = '0;
		for (int i = 0; i < NumChannels; i++) begin
			total = total + OutWidth'(psgPkg::sample_t'(
				chanSample[i*psgPkg::SampleWidth +: psgPkg::SampleWidth]));
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			audioOut <= '0;
		end
		else if (ce) begin
			audioOut <= total;
		end
	end

endmodule

`default_nettype wire

// File: design/psgWaveTop.sv
`timescale 1ns/1ps
`default_nettype none

module psgWaveTop #(
	parameter int NumChannels = 8,
	parameter int AdrWidth = 16,
	localparam int ChanBits = (NumChannels > 1) ? $clog2(NumChannels) : 1,
	localparam int OutWidth = psgPkg::SampleWidth + $clog2(NumChannels)
) (
	input logic clk,
	input logic rst,

	// register writes
	input logic regWr,
	input logic [ChanBits-1:0] regChan,
	input psgPkg::regOp_t regOp,
	input logic [15:0] regData,

	input logic ce,

	// memory side
	output logic busReq,
	output logic [AdrWidth-1:0] busAdr,
	input logic busAck,
	input psgPkg::sample_t busDat,

	output logic signed [OutWidth-1:0] audioOut
);

	logic [NumChannels*AdrWidth-1:0] chanStart;
	logic [NumChannels*psgPkg::IndexWidth-1:0] chanLength;
	logic [NumChannels*psgPkg::PhaseWidth-1:0] chanStep;
	logic [NumChannels-1:0] chanEnable;
	logic [NumChannels-1:0] chanReq;
	logic [NumChannels*AdrWidth-1:0] chanAdr;
	logic [NumChannels*psgPkg::SampleWidth-1:0] chanSample;
	logic [NumChannels-1:0] fetchDone;

	psgRegFile #(.NumChannels(NumChannels), .AdrWidth(AdrWidth)) uRegFile (
		.clk, .rst, .regWr, .regChan, .regOp, .regData,
		.chanStart, .chanLength, .chanStep, .chanEnable
	);

	// ============================================================
	// wave voices
	// ============================================================

	for (genvar i = 0; i < NumChannels; i++) begin : gChan
		psgWaveChannel #(.AdrWidth(AdrWidth)) uChan (
			.clk, .rst, .ce,
			.start(chanStart[i*AdrWidth +: AdrWidth]),
			.length(chanLength[i*psgPkg::IndexWidth +: psgPkg::IndexWidth]),
			.step(chanStep[i*psgPkg::PhaseWidth +: psgPkg::PhaseWidth]),
			.enable(chanEnable[i]),
			.fetchDone(fetchDone[i]),
			.busDat,
			.req(chanReq[i]),
			.adr(chanAdr[i*AdrWidth +: AdrWidth]),
			.sample(chanSample[i*psgPkg::SampleWidth +: psgPkg::SampleWidth])
		);
	end

	// grant and owner index stay inside the arbiter
	psgBusArb #(.NumChannels(NumChannels), .AdrWidth(AdrWidth)) uBusArb (
		.clk, .rst, .ce, .busAck, .chanReq, .chanAdr,
		.sel(), .seln(), .fetchDone, .busReq, .busAdr
	);

	psgMixer #(.NumChannels(NumChannels)) uMixer (
		.clk, .rst, .ce, .chanSample, .audioOut
	);

endmodule

`default_nettype wire

// File: tb/psgBusArb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module psgBusArb_checker #(
	parameter int NumChannels = 8,
	localparam int ChanBits = (NumChannels > 1) ? $clog2(NumChannels) : 1
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic busAck,
	input logic [NumChannels-1:0] sel,
	input logic [ChanBits-1:0] seln,
	input logic [NumChannels-1:0] fetchDone
);

	// running count of property failures, summed into the final report
	int assertFails = 0;

	// ============================================================
	// grant properties
	// ============================================================

	selOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
		else begin
			assertFails++;
			$error("sel has more than one bit set: %b", sel);
		end

	// the owner only moves on an enabled, acknowledged cycle
	selHold: assert property (@(posedge clk) disable iff (rst)
		!(ce && busAck) |=> $stable(sel))
		else begin
			assertFails++;
			$error("sel changed without ce and busAck");
		end

	// a completion pulse goes only to the channel whose address is on the bus
	doneToOwner: assert property (@(posedge clk) disable iff (rst)
		(fetchDone != '0) |-> (fetchDone == (NumChannels'(1) << seln)))
		else begin
			assertFails++;
			$error("fetchDone %b does not match owner %0d", fetchDone, seln);
		end

	selReset: assert property (@(posedge clk) rst |=> (sel == '0))
		else begin
			assertFails++;
			$error("sel not cleared by reset");
		end

endmodule

bind psgBusArb psgBusArb_checker #(.NumChannels(NumChannels)) uChecker (
	.clk, .rst, .ce, .busAck, .sel, .seln, .fetchDone
);

`default_nettype wire

// File: tb/psgWaveTop_tb.sv
`timescale 1ns/1ps
`default_nettype none

module psgWaveTop_tb;

	localparam int NumChannels = 8;
	localparam int AdrWidth = 16;
	localparam int ChanBits = 3;
	localparam int OutWidth = psgPkg::SampleWidth + 3;
	localparam int CyclesPerRecord = 200;
	localparam string PatternFile = "tb/psgWaveTop_patterns.txt";

	logic clk;
	logic rst;
	logic regWr;
	logic [ChanBits-1:0] regChan;
	psgPkg::regOp_t regOp;
	logic [15:0] regData;
	logic ce;
	logic busReq;
	logic [AdrWidth-1:0] busAdr;
	logic busAck;
	psgPkg::sample_t busDat;
	logic signed [OutWidth-1:0] audioOut;

	logic [31:0] rngState;
	int cycleCount;
	int cycleLimit;
	int errorCount;
	int testErrors;
	int testsRun;
	int testsFailed;
	int patternFd;
	bit enableSeen;
	string testName;

	psgWaveTop #(.NumChannels(NumChannels), .AdrWidth(AdrWidth)) uut (
		.clk, .rst, .regWr, .regChan, .regOp, .regData, .ce,
		.busReq, .busAdr, .busAck, .busDat, .audioOut
	);

	// memory model, each byte is its own address scrambled
	assign busDat = psgPkg::sample_t'(busAdr[7:0] ^ 8'h5A);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ============================================================
	// watchdog
	// ============================================================

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	initial begin
		wait (cycleCount > cycleLimit);
		$display("Timeout: run exceeded %0d cycles", cycleLimit);
		$display("TESTS FAILED");
		$finish;
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// mostly high, with the odd stall cycle
	task automatic drawAck(output logic ack);
		rngState = lcgNext(rngState);
		ack = (rngState[31:28] != 4'h0);
	endtask

	task automatic noteError();
		errorCount++;
		testErrors++;
	endtask

	task automatic beginCycle(input logic wr, input logic ack, input logic ceVal);
		@(posedge clk);
		#2;
		regWr = wr;
		busAck = ack;
		ce = ceVal;
	endtask

	// outputs are looked at mid-cycle
	task automatic endCycle();
		@(negedge clk);
		if (!enableSeen && busReq !== 1'b0) begin
			$display("Fail %s busReq expected 0 actual %b", testName, busReq);
			noteError();
		end
	endtask

	// ============================================================
	// record handlers
	// ============================================================

	task automatic writeReg(input int chan, input int op, input logic [15:0] value);
		beginCycle(1'b1, 1'b0, 1'b1);
		regChan = ChanBits'(chan);
		regOp = psgPkg::regOp_t'(op);
		regData = value;
		if (regOp == psgPkg::REG_CTRL && value[0]) begin
			enableSeen = 1'b1;
		end
		endCycle();
	endtask

	task automatic expectFetch(input logic [AdrWidth-1:0] adr);
		logic ack;
		bit done;
		done = 1'b0;
		while (!done) begin
			drawAck(ack);
			beginCycle(1'b0, ack, 1'b1);
			endCycle();
			if (uut.fetchDone != '0) begin
				done = 1'b1;
				if (busReq !== 1'b1) begin
					$display("Fail %s busReq expected 1 actual %b", testName, busReq);
					noteError();
				end
				if (busAdr !== adr) begin
					$display("Fail %s busAdr expected %h actual %h", testName, adr, busAdr);
					noteError();
				end
			end
		end
	endtask

	task automatic checkMix(input int value);
		repeat (10) begin
			beginCycle(1'b0, 1'b0, 1'b1);
			endCycle();
		end
		if (audioOut !== OutWidth'(value)) begin
			$display("Fail %s audioOut expected %0d actual %0d", testName, value, audioOut);
			noteError();
		end
	endtask

	// stall by busAck or by ce, the bus address has to freeze
	task automatic holdBus(input int cycles, input bit stallCe);
		logic [AdrWidth-1:0] heldAdr;
		for (int i = 0; i < cycles; i++) begin
			if (stallCe) begin
				beginCycle(1'b0, 1'b1, 1'b0);
			end
			else begin
				beginCycle(1'b0, 1'b0, 1'b1);
			end
			endCycle();
			if (i == 0) begin
				heldAdr = busAdr;
			end
			else if (busAdr !== heldAdr) begin
				$display("Fail %s busAdr expected %h actual %h", testName, heldAdr, busAdr);
				noteError();
			end
			if (stallCe && uut.fetchDone != '0) begin
				$display("Error in %s: a fetch completed while ce was low", testName);
				noteError();
			end
		end
	endtask

	task automatic finishTest();
		if (testName != "") begin
			testsRun++;
			if (testErrors == 0) begin
				$display("test %s: ok", testName);
			end
			else begin
				testsFailed++;
				$display("test %s: %0d errors", testName, testErrors);
			end
		end
		testErrors = 0;
	endtask

	task automatic runPatterns(input int fd);
		string kind;
		string nameTok;
		string skipped;
		int chan;
		int op;
		int count;
		int value;
		int code;
		logic [15:0] data;
		logic [AdrWidth-1:0] adr;
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", kind);
			if (code != 1) begin
				break;
			end
			if (kind.substr(0, 0) == "#") begin
				code = $fgets(skipped, fd);
			end
			else begin
				cycleLimit += CyclesPerRecord;
				if (kind == "T") begin
					code = $fscanf(fd, "%s", nameTok);
					finishTest();
					testName = nameTok;
				end
				else if (kind == "W") begin
					code = $fscanf(fd, "%d %d %h", chan, op, data);
					writeReg(chan, op, data);
				end
				else if (kind == "E") begin
					code = $fscanf(fd, "%h", adr);
					expectFetch(adr);
				end
				else if (kind == "M") begin
					code = $fscanf(fd, "%d", value);
					checkMix(value);
				end
				else if (kind == "S" || kind == "N") begin
					code = $fscanf(fd, "%d", count);
					holdBus(count, kind == "N");
				end
				else begin
					$display("Error: unknown record %s in the pattern file", kind);
					noteError();
				end
			end
		end
		finishTest();
	endtask

	// ============================================================
	// main sequence
	// ============================================================

	initial begin
		rst = 1'b1;
		regWr = 1'b0;
		regChan = '0;
		regOp = psgPkg::REG_START;
		regData = '0;
		ce = 1'b1;
		busAck = 1'b0;
		rngState = 32'h9443c310;
		cycleLimit = CyclesPerRecord;
		errorCount = 0;
		testErrors = 0;
		testsRun = 0;
		testsFailed = 0;
		enableSeen = 1'b0;
		testName = "";
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		patternFd = $fopen(PatternFile, "r");
		if (patternFd == 0) begin
			$display("Error: cannot open pattern file %s", PatternFile);
			$display("TESTS FAILED");
			$finish;
		end
		else begin
			runPatterns(patternFd);
			$fclose(patternFd);
			// releases a write strobe left by the last record
			beginCycle(1'b0, 1'b0, 1'b1);
			endCycle();
			if (uut.uBusArb.uChecker.assertFails != 0) begin
				$display("Error: arbiter assertions failed %0d times",
					uut.uBusArb.uChecker.assertFails);
				errorCount += uut.uBusArb.uChecker.assertFails;
			end
			$display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
			if (errorCount == 0) begin
				$display("TESTS PASSED");
			end
			else begin
				$display("TESTS FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tb/psgWaveTop_patterns.txt
# W chan op value(hex), op 0 start 1 length 2 step 3 ctrl | E fetch address(hex)
# M audio sum(decimal) | S busAck-low cycles | N ce-low cycles | T test name
T reset
M 0
T priority
W 1 0 0110
W 2 0 0220
W 5 0 05c0
W 5 3 1
W 2 3 1
W 1 3 1
S 2
E 0110
E 0220
E 05c0
T mixing
M 94
T backpressure
W 1 3 0
W 1 0 0130
W 1 3 1
S 8
E 0130
M 126
T clockenable
W 2 3 0
W 2 0 0240
W 2 3 1
N 8
E 0240
M 30
T wrap
W 1 3 0
W 5 3 0
W 2 3 0
W 2 0 0300
W 2 1 4
W 2 2 0040
W 2 3 1
E 0300
E 0301
E 0302
E 0303
E 0300
W 2 3 0
M 0

// File: psgWaveTop.f
design/psgPkg.sv
design/psgRegFile.sv
design/psgWaveChannel.sv
design/psgBusArb.sv
design/psgMixer.sv
design/psgWaveTop.sv
tb/psgBusArb_checker.sv
tb/psgWaveTop_tb.sv
